/* project.f */
common/tilemap_pkg.sv
tilemap/tilemap_ctrl.sv
tilemap/tile_fetch.sv
tilemap/pixel_dump.sv
tilemap/line_buffer.sv
verilog/tilemap_top.sv
tb/tilemap_mem_model.sv
tb/tilemap_tb.sv

/* Bender.yml */
package:
  name: tilemap

sources:
  - common/tilemap_pkg.sv
  - tilemap/tilemap_ctrl.sv
  - tilemap/tile_fetch.sv
  - tilemap/pixel_dump.sv
  - tilemap/line_buffer.sv
  - verilog/tilemap_top.sv
  - target: test
    files:
      - tb/tilemap_mem_model.sv
      - tb/tilemap_tb.sv

/* tb/tilemap_tb.sv */
// tile layer renderer testbench
`timescale 1ns/1ps

module tilemap_tb;

    localparam int DONE_LIMIT = 4000;  // cycles allowed per line render

    logic                            clk;
    logic                            rst;
    logic                            lhbl;
    logic                            lvbl;
    logic [tilemap_pkg::HPOS_W-1:0]  vrender;
    logic [7:0]                      hdump;
    logic [tilemap_pkg::HPOS_W-1:0]  hscroll;
    logic [7:0]                      vscroll;
    logic                            flip;
    logic                            txt_en;
    logic [tilemap_pkg::SCAN_AW-1:0] scan_addr;
    logic [7:0]                      code_scan;
    logic [7:0]                      attr_scan;
    logic                            rom_cs;
    logic [tilemap_pkg::ROM_AW-1:0]  rom_addr;
    logic                            rom_ok;
    logic [tilemap_pkg::ROM_DW-1:0]  rom_data;
    logic [tilemap_pkg::PXL_W-1:0]   pixel;
    logic                            done;

    // scroll, flip and mode of the line now on display
    logic [tilemap_pkg::HPOS_W-1:0]  d_vrender;
    logic [tilemap_pkg::HPOS_W-1:0]  d_hscroll;
    logic [7:0]                      d_vscroll;
    logic                            d_flip;
    logic                            d_txt;

    logic                            chk;
    logic                            chk_q;
    logic [tilemap_pkg::PXL_W-1:0]   exp_px;
    logic [tilemap_pkg::PXL_W-1:0]   exp_q;
    logic                            started;
    logic                            hung;
    int                              errors;
    int                              i;
    integer                          seed = 32'h48c6_b29c;
    logic [31:0]                     rnd;

    tilemap_top tilemap_top_i (.*);

    tilemap_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .scan_addr (scan_addr),
        .code_scan (code_scan),
        .attr_scan (attr_scan),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // same tile map and ROM contents as the memory model
    function automatic logic [15:0] tile_map_word(input logic [10:0] a);
        logic [31:0] h;
        h = {21'd0, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[31:16];
    endfunction

    function automatic logic [15:0] gfx_rom_word(input logic [14:0] a);
        logic [31:0] h;
        h = {17'd0, a} * 32'h85eb_ca6b;
        h = h ^ (h >> 13) ^ 32'h5bd1_e995;
        return h[15:0] ^ h[31:16];
    endfunction

    // expected line buffer entry at read position h
    function automatic logic [6:0] ref_pixel(input logic [7:0] h);
        logic [7:0]  sx;
        logic [8:0]  lx;
        logic [7:0]  row;
        logic [15:0] map;
        logic [10:0] code;
        logic [15:0] word;
        sx   = d_flip ? 8'd255 - h : h;
        lx   = d_txt ? {1'b0, sx} : {1'b0, sx} + d_hscroll;  // layer x
        row  = d_txt ? d_vrender[7:0] : d_vrender[7:0] + d_vscroll;
        row  = row ^ {8{d_flip}};
        map  = tile_map_word({d_txt, row[7:3], lx[7:3]});
        code = {map[15], map[12:11], map[7:0]};
        word = gfx_rom_word({code, row[2:0], lx[2]});
        return {map[10:8], word[15 - 4 * lx[1:0] -: 4]};  // leftmost pixel in top nibble
    endfunction

    // expected value follows the one-cycle read latency
    always @(posedge clk) begin
        chk_q <= chk;
        exp_q <= exp_px;
        if (rst) started <= 1'b0;
        else if (lhbl) started <= 1'b1;
    end

    a_pixel: assert property (@(posedge clk) disable iff (rst) chk_q |-> pixel == exp_q)
        else begin
            errors++;
            $display("[ERROR] %0t pixel expected %h got %h", $time, $sampled(exp_q),
                     $sampled(pixel));
        end

    a_idle: assert property (@(posedge clk) disable iff (rst) !started |-> done && !rom_cs)
        else begin
            errors++;
            $display("%0t: ROM access or done low before the first line start", $time);
        end

    a_addr: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else begin
            errors++;
            $display("%0t: rom_addr changed while waiting for rom_ok", $time);
        end

    a_done_in_time: assert property (@(posedge clk) disable iff (rst)
        $rose(lhbl) && lvbl |-> done)
        else begin
            errors++;
            $display("%0t: new line started before the previous render finished", $time);
        end

    a_done_drop: assert property (@(posedge clk) disable iff (rst)
        $rose(lhbl) && lvbl |=> !done)
        else begin
            errors++;
            $display("[ERROR] %0t done expected 0 got %b", $time, $sampled(done));
        end

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            hung = 1'b1;
            errors++;
            $display("%0t: timed out waiting for done", $time);
        end
    endtask

    // start one line, read out the previous one, then wait for the render
    task automatic run_line(input logic [8:0] vr, input logic [8:0] hs, input logic [7:0] vs,
                            input logic fl, input logic tx, input logic rd);
        int h;
        d_vrender = vrender;
        d_hscroll = hscroll;
        d_vscroll = vscroll;
        d_flip    = flip;
        d_txt     = txt_en;
        @(negedge clk);
        lhbl    = 1'b0;
        vrender = vr;
        hscroll = hs;
        vscroll = vs;
        flip    = fl;
        txt_en  = tx;
        @(negedge clk);
        lhbl = 1'b1;  // rising edge starts the line
        @(negedge clk);
        if (rd) begin
            for (h = 0; h < 256; h++) begin
                hdump  = h[7:0];
                exp_px = ref_pixel(h[7:0]);
                chk    = 1'b1;
                @(negedge clk);
            end
            chk = 1'b0;
        end
        wait_done();
    endtask

    initial begin
        rst     = 1'b1;
        lhbl    = 1'b0;
        lvbl    = 1'b1;
        vrender = '0;
        hdump   = 8'd0;
        hscroll = '0;
        vscroll = 8'd0;
        flip    = 1'b0;
        txt_en  = 1'b0;
        chk     = 1'b0;
        exp_px  = '0;
        hung    = 1'b0;
        errors  = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (5) @(negedge clk);  // idle window before any line

        run_line(9'd16, 9'd0, 8'd0, 1'b0, 1'b0, 1'b0);    // nothing on display yet
        run_line(9'd17, 9'd0, 8'd0, 1'b0, 1'b0, 1'b1);
        run_line(9'd200, 9'd3, 8'd1, 1'b0, 1'b0, 1'b1);   // fine scroll
        run_line(9'd45, 9'h1ff, 8'hfe, 1'b0, 1'b0, 1'b1); // wraps both ways
        for (i = 0; i < 4; i++) begin
            rnd = $random(seed);
            run_line({1'b0, rnd[31:24]}, rnd[8:0], rnd[16:9], 1'b0, 1'b0, 1'b1);
        end
        run_line(9'd30, 9'd77, 8'd99, 1'b0, 1'b1, 1'b1);  // text mode
        run_line(9'd31, 9'd5, 8'd3, 1'b1, 1'b0, 1'b1);    // flipped
        run_line(9'd32, 9'd6, 8'd7, 1'b1, 1'b1, 1'b1);
        run_line(9'd33, 9'd0, 8'd0, 1'b0, 1'b0, 1'b1);    // shows the last line

        $display("tilemap_tb finished with %0d errors", errors);
        if (errors == 0 && !hung) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb/tilemap_mem_model.sv */
// tile map and graphics ROM model
`timescale 1ns/1ps

module tilemap_mem_model (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [tilemap_pkg::SCAN_AW-1:0]   scan_addr,
    output logic [7:0]                        code_scan,
    output logic [7:0]                        attr_scan,
    input  logic                              rom_cs,
    input  logic [tilemap_pkg::ROM_AW-1:0]    rom_addr,
    output logic                              rom_ok,
    output logic [tilemap_pkg::ROM_DW-1:0]    rom_data
);

    integer      seed = 32'h48c6_b29c;
    logic [31:0] rnd;
    logic [1:0]  wait_cnt;  // cycles left before rom_ok

    // {attr, code} for one tile-map entry
    function automatic logic [15:0] tile_map_word(input logic [10:0] a);
        logic [31:0] h;
        h = {21'd0, a} * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return h[31:16];
    endfunction

    function automatic logic [15:0] gfx_rom_word(input logic [14:0] a);
        logic [31:0] h;
        h = {17'd0, a} * 32'h85eb_ca6b;
        h = h ^ (h >> 13) ^ 32'h5bd1_e995;
        return h[15:0] ^ h[31:16];
    endfunction

    assign {attr_scan, code_scan} = tile_map_word(scan_addr);

    assign rom_ok   = rom_cs && wait_cnt == 2'd0;
    assign rom_data = rom_ok ? gfx_rom_word(rom_addr) : 16'hxxxx;  // only valid with ok

    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 2'd0;
        end else if (!rom_cs) begin
            // new delay of 0 to 3 cycles for the next request
            rnd = $random(seed);
            wait_cnt <= rnd[1:0];
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

/* verilog/tilemap_top.sv */
// background tile layer renderer
`timescale 1ns/1ps

module tilemap_top (
    input  logic                              clk,
    input  logic                              rst,
    // video timing
    input  logic                              lhbl,
    input  logic                              lvbl,
    input  logic [tilemap_pkg::HPOS_W-1:0]    vrender,
    input  logic [7:0]                        hdump,
    // configuration
    input  logic [tilemap_pkg::HPOS_W-1:0]    hscroll,
    input  logic [7:0]                        vscroll,
    input  logic                              flip,
    input  logic                              txt_en,
    // tile map scan
    output logic [tilemap_pkg::SCAN_AW-1:0]   scan_addr,
    input  logic [7:0]                        code_scan,
    input  logic [7:0]                        attr_scan,
    // graphics ROM
    output logic                              rom_cs,
    output logic [tilemap_pkg::ROM_AW-1:0]    rom_addr,
    input  logic                              rom_ok,
    input  logic [tilemap_pkg::ROM_DW-1:0]    rom_data,
    // video out
    output logic [tilemap_pkg::PXL_W-1:0]     pixel,
    output logic                              done
);

    logic                            line;
    logic                            line_start;
    logic                            row_ld;
    logic                            tile_ld;
    logic                            col_adv;
    logic                            word_ld;
    logic                            shift_en;
    logic                            hn_lsb2;
    logic                            col_end;
    logic                            dump_last;
    logic [2:0]                      pal;
    logic [1:0]                      hstart_ofs;
    logic                            we;
    logic [tilemap_pkg::LBUF_AW-1:0] waddr;
    logic [tilemap_pkg::PXL_W-1:0]   wdata;

    tilemap_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .rom_ok     (rom_ok),
        .hn_lsb2    (hn_lsb2),
        .col_end    (col_end),
        .dump_last  (dump_last),
        .line       (line),
        .done       (done),
        .rom_cs     (rom_cs),
        .line_start (line_start),
        .row_ld     (row_ld),
        .tile_ld    (tile_ld),
        .col_adv    (col_adv),
        .word_ld    (word_ld),
        .shift_en   (shift_en)
    );

    tile_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .row_ld     (row_ld),
        .tile_ld    (tile_ld),
        .col_adv    (col_adv),
        .hscroll    (hscroll),
        .vscroll    (vscroll),
        .vrender    (vrender),
        .flip       (flip),
        .txt_en     (txt_en),
        .code_scan  (code_scan),
        .attr_scan  (attr_scan),
        .scan_addr  (scan_addr),
        .rom_addr   (rom_addr),
        .pal        (pal),
        .hn_lsb2    (hn_lsb2),
        .col_end    (col_end),
        .hstart_ofs (hstart_ofs)
    );

    pixel_dump u_dump (
        .clk        (clk),
        .rst        (rst),
        .word_ld    (word_ld),
        .shift_en   (shift_en),
        .rom_data   (rom_data),
        .pal        (pal),
        .hstart_ofs (hstart_ofs),
        .flip       (flip),
        .line       (line),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .dump_last  (dump_last)
    );

    line_buffer u_lbuf (
        .clk   (clk),
        .we    (we),
        .waddr (waddr),
        .wdata (wdata),
        .line  (line),
        .hdump (hdump),
        .pixel (pixel)
    );

endmodule

/* tilemap/line_buffer.sv */
// double line buffer
`timescale 1ns/1ps

module line_buffer (
    input  logic                              clk,
    input  logic                              we,
    input  logic [tilemap_pkg::LBUF_AW-1:0]   waddr,
    input  logic [tilemap_pkg::PXL_W-1:0]     wdata,
    input  logic                              line,
    input  logic [7:0]                        hdump,
    output logic [tilemap_pkg::PXL_W-1:0]     pixel
);

    localparam int DEPTH = 1 << tilemap_pkg::LBUF_AW;

    logic [tilemap_pkg::PXL_W-1:0]   mem [DEPTH];
    logic [tilemap_pkg::LBUF_AW-1:0] raddr;

    // video side reads the half not being rendered
    assign raddr = {~line, hdump};

    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    always_ff @(posedge clk) begin
        pixel <= mem[raddr];  // one cycle after hdump
    end

    // render writes must stay in the half selected by line
    a_half: assert property (@(posedge clk)
        we |-> waddr[tilemap_pkg::LBUF_AW-1] == line)
        else $error("write into the half on display");

endmodule

/* tilemap/pixel_dump.sv */
// ROM word to line buffer pixels
`timescale 1ns/1ps

module pixel_dump (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              word_ld,
    input  logic                              shift_en,
    input  logic [tilemap_pkg::ROM_DW-1:0]    rom_data,
    input  logic [2:0]                        pal,
    input  logic [1:0]                        hstart_ofs,
    input  logic                              flip,
    input  logic                              line,
    output logic                              we,
    output logic [tilemap_pkg::LBUF_AW-1:0]   waddr,
    output logic [tilemap_pkg::PXL_W-1:0]     wdata,
    output logic                              dump_last
);

    logic [tilemap_pkg::ROM_DW-1:0] pxl_data;
    logic [1:0]                     sh_cnt;
    logic [8:0]                     lx;        // layer x relative to first column
    logic                           line_q;
    logic [9:0]                     sx;        // screen x which goes negative at the left
    logic                           visible;

    assign sx        = {1'b0, lx} - {8'd0, hstart_ofs};
    assign visible   = sx < 10'(tilemap_pkg::LINE_W);
    assign dump_last = shift_en && sh_cnt == 2'd3;

    always_ff @(posedge clk) begin
        if (rst) begin
            we     <= 1'b0;
            sh_cnt <= 2'd0;
            lx     <= 9'd0;
            line_q <= 1'b0;
        end else begin
            line_q <= line;
            we     <= shift_en && visible;
            if (line != line_q) lx <= 9'd0;  // halves swapped so start again
            else if (shift_en) lx <= lx + 9'd1;
            if (word_ld) sh_cnt <= 2'd0;
            else if (shift_en) sh_cnt <= sh_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_ld) pxl_data <= rom_data;
        else if (shift_en) pxl_data <= pxl_data << 4;  // top nibble first
        if (shift_en) begin
            wdata <= {pal, pxl_data[15:12]};
            waddr <= {line, flip ? 8'd255 - sx[7:0] : sx[7:0]};
        end
    end

    a_we_burst: assert property (@(posedge clk) disable iff (rst)
        we [*4] |=> !we)
        else $error("more than four writes in a row");

endmodule

/* tilemap/tile_fetch.sv */
// tile map scan and ROM addressing
`timescale 1ns/1ps

module tile_fetch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              line_start,
    input  logic                              row_ld,
    input  logic                              tile_ld,
    input  logic                              col_adv,
    input  logic [tilemap_pkg::HPOS_W-1:0]    hscroll,
    input  logic [7:0]                        vscroll,
    input  logic [tilemap_pkg::HPOS_W-1:0]    vrender,
    input  logic                              flip,
    input  logic                              txt_en,
    input  logic [7:0]                        code_scan,
    input  logic [7:0]                        attr_scan,
    output logic [tilemap_pkg::SCAN_AW-1:0]   scan_addr,
    output logic [tilemap_pkg::ROM_AW-1:0]    rom_addr,
    output logic [2:0]                        pal,
    output logic                              hn_lsb2,
    output logic                              col_end,
    output logic [1:0]                        hstart_ofs
);

    logic [tilemap_pkg::HPOS_W-1:0] hn_base;   // layer x of first column
    logic [tilemap_pkg::HPOS_W-1:0] col_cnt;   // pixels issued this line
    logic [tilemap_pkg::HPOS_W-1:0] hn;        // current layer x
    logic [7:0]                     vn;        // layer row
    logic [7:0]                     vsum;
    logic [tilemap_pkg::CODE_W-1:0] code;
    logic [9:0]                     nxt_col;
    logic [9:0]                     last_px;

    assign hn      = hn_base + col_cnt;
    assign hn_lsb2 = hn[2];

    // text mode ignores vertical scroll
    assign vsum = txt_en ? vrender[7:0] : vrender[7:0] + vscroll;

    assign scan_addr = {txt_en, vn[7:3], hn[7:3]};
    assign rom_addr  = {code, vn[2:0], hn[2]};

    // done once the next column starts past the last visible pixel
    assign nxt_col = {1'b0, col_cnt} + 10'd4;
    assign last_px = 10'(tilemap_pkg::LINE_W - 1) + {8'd0, hstart_ofs};
    assign col_end = nxt_col > last_px;

    always_ff @(posedge clk) begin
        if (rst) begin
            hn_base    <= '0;
            col_cnt    <= '0;
            hstart_ofs <= 2'd0;
            vn         <= 8'd0;
        end else begin
            if (line_start) begin
                hn_base    <= txt_en ? '0 : {hscroll[tilemap_pkg::HPOS_W-1:2], 2'b00};
                hstart_ofs <= txt_en ? 2'd0 : hscroll[1:0];  // fine scroll
                col_cnt    <= '0;
            end else if (col_adv) begin
                col_cnt <= col_cnt + 9'd4;
            end
            if (row_ld) vn <= vsum ^ {8{flip}};
        end
    end

    // tile info straight from the scan port
    always_ff @(posedge clk) begin
        if (tile_ld) begin
            code <= {attr_scan[7], attr_scan[4:3], code_scan};
            pal  <= attr_scan[2:0];
        end
    end

endmodule

/* tilemap/tilemap_ctrl.sv */
// tile layer line controller
`timescale 1ns/1ps

module tilemap_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic lhbl,
    input  logic lvbl,
    input  logic rom_ok,
    input  logic hn_lsb2,
    input  logic col_end,
    input  logic dump_last,
    output logic line,
    output logic done,
    output logic rom_cs,
    output logic line_start,
    output logic row_ld,
    output logic tile_ld,
    output logic col_adv,
    output logic word_ld,
    output logic shift_en
);

    tilemap_pkg::render_st_e st;
    logic last_lhbl;
    logic hb_edge;

    // rising edge of lhbl outside vertical blank
    assign hb_edge    = lhbl && !last_lhbl && lvbl;

    assign line_start = st == tilemap_pkg::ST_SETUP;
    assign row_ld     = st == tilemap_pkg::ST_ROW;
    assign tile_ld    = st == tilemap_pkg::ST_SCAN;
    assign col_adv    = st == tilemap_pkg::ST_NEXT && !col_end;
    assign word_ld    = rom_cs && rom_ok;    // ROM acceptance
    // no shift in the cycle that swaps halves
    assign shift_en   = st == tilemap_pkg::ST_DUMP && !hb_edge;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lhbl <= 1'b1;  // needs a real low-to-high edge
            line      <= 1'b0;
            done      <= 1'b1;
            rom_cs    <= 1'b0;
            st        <= tilemap_pkg::ST_IDLE;
        end else begin
            last_lhbl <= lhbl;
            if (hb_edge) begin
                // a new line abandons whatever was in flight
                line   <= ~line;
                done   <= 1'b0;
                rom_cs <= 1'b0;
                st     <= tilemap_pkg::ST_SETUP;
            end else begin
                case (st)
                    tilemap_pkg::ST_SETUP: begin
                        st <= tilemap_pkg::ST_ROW;
                    end
                    tilemap_pkg::ST_ROW: begin
                        st <= tilemap_pkg::ST_SCAN;
                    end
                    tilemap_pkg::ST_SCAN: begin
                        rom_cs <= 1'b1;
                        st     <= tilemap_pkg::ST_ROM;
                    end
                    tilemap_pkg::ST_ROM: begin
                        if (word_ld) begin
                            rom_cs <= 1'b0;
                            st     <= tilemap_pkg::ST_DUMP;
                        end
                    end
                    tilemap_pkg::ST_DUMP: begin
                        if (dump_last) st <= tilemap_pkg::ST_NEXT;
                    end
                    tilemap_pkg::ST_NEXT: begin
                        if (col_end) begin
                            done <= 1'b1;
                            st   <= tilemap_pkg::ST_IDLE;
                        end else if (!hn_lsb2) begin
                            // second half of the same tile
                            rom_cs <= 1'b1;
                            st     <= tilemap_pkg::ST_ROM;
                        end else begin
                            // next tile reloads the row for scroll
                            st <= tilemap_pkg::ST_ROW;
                        end
                    end
                    default: st <= tilemap_pkg::ST_IDLE;
                endcase
            end
        end
    end

    a_cs_done: assert property (@(posedge clk) disable iff (rst)
        !(rom_cs && done))
        else $error("rom_cs high after the line finished");

    // acceptance belongs to the ROM wait state
    a_ld_rom: assert property (@(posedge clk) disable iff (rst)
        word_ld |-> st == tilemap_pkg::ST_ROM)
        else $error("ROM word accepted outside ST_ROM");

endmodule

/* common/tilemap_pkg.sv */
// tile layer shared definitions

package tilemap_pkg;

    // visible pixels per line
    localparam int LINE_W  = 256;

    // layer coordinate width for h and v
    localparam int HPOS_W  = 9;

    // tile-map scan address as {txt half, row[4:0], col[4:0]}
    localparam int SCAN_AW = 11;

    // tile code as {attr[7], attr[4:3], code byte}
    localparam int CODE_W  = 11;

    // graphics ROM word address as {code, tile row, half-tile}
    localparam int ROM_AW  = 15;
    localparam int ROM_DW  = 16;  // four 4-bit pixels per word

    // line buffer entry as {palette, colour index}
    localparam int PXL_W   = 7;

    // line buffer address as {half, x}
    localparam int LBUF_AW = 9;

    // per-line controller states
    typedef enum logic [2:0] {
        ST_IDLE,   // waiting for a line start
        ST_SETUP,  // latch scroll origin
        ST_ROW,    // compute layer row
        ST_SCAN,   // latch tile info
        ST_ROM,    // wait for ROM data
        ST_DUMP,   // shift out pixels
        ST_NEXT    // advance or finish
    } render_st_e;

endpackage
